// File: src/colmix_pkg.sv
`default_nettype none

package colmix_pkg;

    // one palette pixel
    // low nibble is the colour index, upper bits select the palette
    typedef logic [8:0] pix_t;

    // pixel position inside a line buffer
    typedef logic [8:0] pix_addr_t;

    // done flags of layers 1 to 3, bit 0 is layer 1
    typedef logic [2:0] layer_done_t;

    // visible pixels per line
    localparam int unsigned LINE_PIXELS = 448;

    // last visible address, end of the dump
    localparam pix_addr_t LAST_PIX_ADDR = pix_addr_t'(LINE_PIXELS - 1);

    // line buffer depth, full address range
    localparam int unsigned BUF_DEPTH = 512;

    // colour index 15 is see-through
    localparam logic [3:0] TRANSP_CODE = 4'hf;

    // write from one scroll renderer
    typedef struct packed {
        logic      wr;
        pix_addr_t addr;
        pix_t      pix;
    } layer_wr_t;

    // write towards the frame buffer
    typedef struct packed {
        pix_addr_t addr;
        pix_t      pix;
    } line_wr_t;

    // mixer sequencer
    typedef enum logic [1:0] {
        FILL,
        READ,
        PRESENT,
        DONE
    } mix_state_t;

endpackage

`default_nettype wire

// File: src/layer_line_buf.sv
`timescale 1ns/1ps
`default_nettype none

module layer_line_buf (
    input  wire                   clk,
    // renderer writes only land while this is high
    input  wire                   fill,
    input  wire colmix_pkg::layer_wr_t wr_in,
    input  wire colmix_pkg::pix_addr_t rd_addr,
    output colmix_pkg::pix_t      rd_pix
);
    import colmix_pkg::*;

    // one layer line
    // the top 64 entries are never shown but still writable
    pix_t mem [BUF_DEPTH];

    // write strobe qualified by the fill window
    logic wr_en;

    assign wr_en = fill & wr_in.wr;

    // write port
    // strobes outside the fill window are dropped
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_in.addr] <= wr_in.pix;
        end
    end

    // registered read port
    // data follows rd_addr by one cycle
    always_ff @(posedge clk) begin
        rd_pix <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: src/line_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module line_mixer (
    input  wire                         clk,
    input  wire                         rst,
    // level flags from the three renderers
    input  wire colmix_pkg::layer_done_t scr_done,
    // re-arm pulse, only honoured in DONE
    input  wire                         start,
    // buffer read data, one cycle behind rd_addr
    input  wire colmix_pkg::pix_t       scr1_pix,
    input  wire colmix_pkg::pix_t       scr2_pix,
    input  wire colmix_pkg::pix_t       scr3_pix,
    // buffer control
    output logic                        fill,
    output colmix_pkg::pix_addr_t       rd_addr,
    // frame buffer port
    output colmix_pkg::line_wr_t        line,
    output logic                        line_wr,
    input  wire                         line_wr_ok,
    output logic                        line_done
);
    import colmix_pkg::*;

    mix_state_t state;

    // read data for rd_addr is sitting in the buffer registers
    logic rd_valid;

    // all three layers finished rendering
    logic all_done;

    // transfer accepted by the frame buffer this edge
    logic xfer;

    // merged pixel for the current read
    pix_t mix_pix;

    assign all_done = &scr_done;
    assign xfer     = line_wr & line_wr_ok;

    // renderers may only write while filling
    assign fill = (state == FILL);

    // fixed priority, layer 1 on top
    // layer 3 is the backdrop and is taken as is
    always_comb begin
        if (scr1_pix[3:0] != TRANSP_CODE) begin
            mix_pix = scr1_pix;
        end else if (scr2_pix[3:0] != TRANSP_CODE) begin
            mix_pix = scr2_pix;
        end else begin
            mix_pix = scr3_pix;
        end
    end

    // sequencer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= FILL;
            rd_addr   <= '0;
            rd_valid  <= 1'b0;
            line      <= '0;
            line_wr   <= 1'b0;
            line_done <= 1'b0;
        end else begin
            case (state)
                FILL: begin
                    // dump always starts from pixel 0
                    rd_addr  <= '0;
                    rd_valid <= 1'b0;
                    if (all_done) begin
                        state <= READ;
                    end
                end

                READ: begin
                    if (!rd_valid) begin
                        // address out this cycle
                        // buffer data lands on this edge
                        rd_valid <= 1'b1;
                    end else begin
                        // merge and present, address is the one read
                        line.addr <= rd_addr;
                        line.pix  <= mix_pix;
                        line_wr   <= 1'b1;
                        rd_valid  <= 1'b0;
                        state     <= PRESENT;
                    end
                end

                PRESENT: begin
                    // line and line_wr hold until the frame buffer takes it
                    if (xfer) begin
                        line_wr <= 1'b0;
                        if (rd_addr == LAST_PIX_ADDR) begin
                            line_done <= 1'b1;
                            state     <= DONE;
                        end else begin
                            rd_addr <= rd_addr + 1'b1;
                            state   <= READ;
                        end
                    end
                end

                DONE: begin
                    // line_done stays up until re-armed
                    if (start) begin
                        line_done <= 1'b0;
                        state     <= FILL;
                    end
                end

                default: begin
                    state <= FILL;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/colmix_top.sv
`timescale 1ns/1ps
`default_nettype none

module colmix_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          start,
    // scroll renderer writes
    input  wire colmix_pkg::layer_wr_t   scr1,
    input  wire colmix_pkg::layer_wr_t   scr2,
    input  wire colmix_pkg::layer_wr_t   scr3,
    input  wire colmix_pkg::layer_done_t scr_done,
    // frame buffer side
    output wire colmix_pkg::line_wr_t    line,
    output wire                          line_wr,
    input  wire                          line_wr_ok,
    output wire                          line_done
);
    import colmix_pkg::*;

    // fill window shared by all buffers
    wire fill;

    // common read address during the dump
    pix_addr_t rd_addr;

    // per layer read data
    pix_t buf1_pix;
    pix_t buf2_pix;
    pix_t buf3_pix;

    // layer 1, highest priority
    layer_line_buf buf1 (
        .clk     (clk),
        .fill    (fill),
        .wr_in   (scr1),
        .rd_addr (rd_addr),
        .rd_pix  (buf1_pix)
    );

    // layer 2
    layer_line_buf buf2 (
        .clk     (clk),
        .fill    (fill),
        .wr_in   (scr2),
        .rd_addr (rd_addr),
        .rd_pix  (buf2_pix)
    );

    // layer 3, backdrop
    layer_line_buf buf3 (
        .clk     (clk),
        .fill    (fill),
        .wr_in   (scr3),
        .rd_addr (rd_addr),
        .rd_pix  (buf3_pix)
    );

    // sequencer and priority merge
    line_mixer mixer0 (
        .clk        (clk),
        .rst        (rst),
        .scr_done   (scr_done),
        .start      (start),
        .scr1_pix   (buf1_pix),
        .scr2_pix   (buf2_pix),
        .scr3_pix   (buf3_pix),
        .fill       (fill),
        .rd_addr    (rd_addr),
        .line       (line),
        .line_wr    (line_wr),
        .line_wr_ok (line_wr_ok),
        .line_done  (line_done)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // reset held for 16 rising edges, released just after the edge
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: testbench/tb_colmix.sv
`timescale 1ns/1ps
`default_nettype none

module tb_colmix;
    import colmix_pkg::*;

    localparam int NUM_LINES      = 5;
    // addresses per layer left unwritten on lines after the first
    localparam int NSKIP          = 16;
    localparam int TIMEOUT_CYCLES = NUM_LINES * (LINE_PIXELS * 8 + 2000);

    // where the run is, seen by the monitor
    typedef enum logic [1:0] {
        PH_FILL,
        PH_DUMP,
        PH_END
    } phase_t;

    logic        clk;
    logic        rst;
    logic        start;
    layer_wr_t   scr [3];
    layer_done_t scr_done;
    line_wr_t    line;
    logic        line_wr;
    logic        line_wr_ok;
    logic        line_done;

    // renderer model state, index 0 is layer 1
    pix_t      model [3][LINE_PIXELS];
    pix_addr_t ord [3][LINE_PIXELS];
    pix_t      exp_line [LINE_PIXELS];

    phase_t   phase;
    int       xfer_count;
    int       cycle_count;
    logic     hold_valid;
    line_wr_t held_line;

    tb_clock clk_gen0 (
        .clk (clk),
        .rst (rst)
    );

    colmix_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .scr1       (scr[0]),
        .scr2       (scr[1]),
        .scr3       (scr[2]),
        .scr_done   (scr_done),
        .line       (line),
        .line_wr    (line_wr),
        .line_wr_ok (line_wr_ok),
        .line_done  (line_done)
    );

    task automatic check_pix(input line_wr_t got, input line_wr_t want, input string what);
        if (got !== want) begin
            $display("Error at %0t: %s, got addr %0d pix 0x%03h, expected addr %0d pix 0x%03h",
                     $time, what, got.addr, got.pix, want.addr, want.pix);
            $display("SIMULATION FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("Error at %0t: %s, got %b, expected %b", $time, what, got, want);
            $display("SIMULATION FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // random pixel, roughly a third see-through
    function automatic pix_t rand_pix();
        pix_t p;
        p = pix_t'($urandom);
        if ($urandom % 3 == 0) begin
            p[3:0] = TRANSP_CODE;
        end
        return p;
    endfunction

    // layer 3 unless a higher layer shows colour, layer 1 checked last so it wins
    function automatic pix_t merge_pix(input int a);
        pix_t p;
        p = model[2][a];
        for (int l = 1; l >= 0; l--) begin
            if (model[l][a][3:0] != TRANSP_CODE) begin
                p = model[l][a];
            end
        end
        return p;
    endfunction

    // fresh write order per layer, Fisher-Yates
    task automatic shuffle_orders();
        int j;
        pix_addr_t t;
        for (int l = 0; l < 3; l++) begin
            for (int i = 0; i < LINE_PIXELS; i++) begin
                ord[l][i] = pix_addr_t'(i);
            end
            for (int i = LINE_PIXELS - 1; i > 0; i--) begin
                j = $urandom % (i + 1);
                t = ord[l][i];
                ord[l][i] = ord[l][j];
                ord[l][j] = t;
            end
        end
    endtask

    // renderer model, first nskip entries of each order are left alone
    task automatic fill_line(input int nskip);
        int pos [3];
        int wait_cnt [3];
        layer_done_t done_bits;
        logic raised;
        layer_wr_t w;
        for (int l = 0; l < 3; l++) begin
            pos[l] = nskip;
            wait_cnt[l] = $urandom % 24;
        end
        done_bits = '0;
        while (done_bits != 3'b111) begin
            @(posedge clk);
            #1;
            // at most one done bit rises per cycle
            raised = 1'b0;
            for (int l = 0; l < 3; l++) begin
                w = '0;
                if (pos[l] < LINE_PIXELS) begin
                    if ($urandom % 2 == 0) begin
                        w.wr   = 1'b1;
                        w.addr = ord[l][pos[l]];
                        w.pix  = rand_pix();
                        model[l][w.addr] = w.pix;
                        pos[l]++;
                    end
                end else if (!done_bits[l]) begin
                    if (wait_cnt[l] > 0) begin
                        wait_cnt[l]--;
                    end else if (!raised) begin
                        done_bits[l] = 1'b1;
                        raised = 1'b1;
                    end
                end
                scr[l] = w;
            end
            scr_done = done_bits;
        end
        for (int a = 0; a < LINE_PIXELS; a++) begin
            exp_line[a] = merge_pix(a);
        end
        xfer_count = 0;
        phase = PH_DUMP;
    endtask

    // stray writes into next line's skipped addresses, plus one stray start
    task automatic dump_line();
        int cyc;
        int start_at;
        logic finished;
        layer_wr_t w;
        cyc = 0;
        start_at = 4 + $urandom % 200;
        finished = 1'b0;
        while (!finished) begin
            @(posedge clk);
            #1;
            if (line_done) begin
                finished = 1'b1;
                start = 1'b0;
                for (int l = 0; l < 3; l++) begin
                    scr[l] = '0;
                end
            end else begin
                for (int l = 0; l < 3; l++) begin
                    w = '0;
                    if ($urandom % 3 == 0) begin
                        w.wr   = 1'b1;
                        w.addr = ord[l][$urandom % NSKIP];
                        w.pix  = pix_t'($urandom);
                    end
                    scr[l] = w;
                end
                start = (cyc == start_at);
                cyc++;
            end
        end
    endtask

    // idle in DONE for a while, then re-arm unless this was the last line
    task automatic end_line(input logic last);
        int gap;
        scr_done = '0;
        gap = 2 + $urandom % 14;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        if (!last) begin
            start = 1'b1;
            @(posedge clk);
            #1;
            start = 1'b0;
            phase = PH_FILL;
        end
    endtask

    // frame buffer model, accepts about 60% of cycles
    initial begin
        line_wr_ok = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            line_wr_ok = ($urandom % 10) < 6;
        end
    end

    // output monitor, mid cycle where everything is settled
    always @(negedge clk) begin
        line_wr_t want;
        if (!rst) begin
            // stalled last cycle, nothing may move
            if (hold_valid) begin
                check_flag(line_wr, 1'b1, "line_wr dropped while stalled");
                check_pix(line, held_line, "line changed while stalled");
            end
            case (phase)
                PH_FILL: begin
                    check_flag(line_wr, 1'b0, "line_wr before all layers done");
                    check_flag(line_done, 1'b0, "line_done during fill");
                end
                PH_DUMP: begin
                    check_flag(line_done, 1'b0, "line_done before last pixel");
                end
                PH_END: begin
                    check_flag(line_wr, 1'b0, "line_wr after line_done");
                    check_flag(line_done, 1'b1, "line_done fell before start");
                end
                default: begin
                end
            endcase
            // transfer happens on the coming edge
            if (line_wr && line_wr_ok) begin
                want.addr = pix_addr_t'(xfer_count);
                want.pix  = exp_line[xfer_count];
                check_pix(line, want, "merged pixel");
                xfer_count++;
                if (xfer_count == LINE_PIXELS) begin
                    phase = PH_END;
                end
            end
            hold_valid = line_wr && !line_wr_ok;
            held_line  = line;
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d clock cycles", cycle_count);
            $display("SIMULATION FAILED");
            $fatal(1, "run aborted on timeout");
        end
    end

    initial begin
        void'($urandom(32'h3c97_5008));
        start       = 1'b0;
        scr_done    = '0;
        for (int l = 0; l < 3; l++) begin
            scr[l] = '0;
        end
        phase       = PH_FILL;
        xfer_count  = 0;
        cycle_count = 0;
        hold_valid  = 1'b0;
        held_line   = '0;
        shuffle_orders();
        wait (rst == 1'b0);
        for (int n = 0; n < NUM_LINES; n++) begin
            // first line writes everything, buffers start undefined
            fill_line((n == 0) ? 0 : NSKIP);
            shuffle_orders();
            dump_line();
            end_line(n == NUM_LINES - 1);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: colmix.f
src/colmix_pkg.sv
src/layer_line_buf.sv
src/line_mixer.sv
src/colmix_top.sv
testbench/tb_clock.sv
testbench/tb_colmix.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the colour mixer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_colmix \
    -f colmix.f \
    -o tb_colmix_sim

status=0
./obj_dir/tb_colmix_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^SIMULATION PASSED$" sim.log; then
    echo "run_sim: pass found in sim.log"
    exit 0
fi

echo "run_sim: no pass in sim.log, simulator status ${status}"
exit 1
